// ==== src/square_apu_pkg.sv ====
package square_apu_pkg;

   // field widths
   localparam int FREQ_W      = 11;
   localparam int DUTY_W      = 2;
   localparam int VOL_W       = 4;
   localparam int PERIOD_W    = 10;        // largest period is 750 strobes
   localparam int SAMPLE_W    = 20;

   localparam int SYNC_STAGES = 3;         // flops per setting crossing
   localparam int AMP_STEP    = 16384;     // sample units per volume step
   localparam int MIN_PERIOD  = 2;         // shortest legal period in strobes

   // tone math constants
   localparam int SAMPLE_RATE = 48000;     // strobes per second
   localparam int TONE_NUM    = 131072;    // tone hz = 2^17 / (2^11 - code)
   localparam int FREQ_SPAN   = 2 ** FREQ_W;

   typedef logic        [FREQ_W-1:0]   freq_t;
   typedef logic        [DUTY_W-1:0]   duty_t;
   typedef logic        [VOL_W-1:0]    vol_t;
   typedef logic        [PERIOD_W-1:0] period_t;
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // duty select encoding, high share of the period
   typedef enum logic [DUTY_W-1:0] {
      DUTY_12 = 2'd0,   // 12.5%
      DUTY_25 = 2'd1,
      DUTY_50 = 2'd2,
      DUTY_75 = 2'd3
   } duty_e;

   // strobes in one tone period, clamped at the bottom
   function automatic period_t strobes_per_period(input freq_t code);
      int unsigned quot;
      quot = (SAMPLE_RATE * (FREQ_SPAN - code)) / TONE_NUM;
      if (quot < MIN_PERIOD) begin
         return period_t'(MIN_PERIOD);
      end
      return period_t'(quot);   // code 0 gives 750, fits PERIOD_W
   endfunction

endpackage

// ==== src/cfg_sync.sv ====
module cfg_sync
   import square_apu_pkg::*;
#(
   parameter type payload_t = logic   // freq, duty, volume or enable
) (
   input  logic     I_BITCLK,
   input  logic     I_RESET,
   input  payload_t async_in,         // level from outside, changes any time
   output payload_t sync_out          // settled copy, 3 edges later
);

   payload_t stage [SYNC_STAGES];     // stage 0 may go metastable

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         for (int i = 0; i < SYNC_STAGES; i++) begin
            stage[i] <= '0;
         end
      end else begin
         stage[0] <= async_in;        // first capture
         for (int i = 1; i < SYNC_STAGES; i++) begin
            stage[i] <= stage[i-1];   // shift down the chain
         end
      end
   end

   // last stage only goes out
   assign sync_out = stage[SYNC_STAGES-1];

endmodule

// ==== src/period_rom.sv ====
module period_rom
   import square_apu_pkg::*;
(
   input  logic    I_BITCLK,
   input  freq_t   freq,      // synchronized frequency code
   output period_t period     // strobes per tone period, one edge late
);

   // one entry per frequency code
   period_t rom [FREQ_SPAN];

   // table contents come straight from the tone formula
   initial begin
      for (int i = 0; i < FREQ_SPAN; i++) begin
         rom[i] = strobes_per_period(freq_t'(i));
      end
   end

   // registered read like a block ram port
   always_ff @(posedge I_BITCLK) begin
      period <= rom[freq];
   end

   // the address is reset-cleared one edge in and read on the next,
   // so from the third edge on the output is a real table entry
   // and a zero or one period would stall or break the duty split
   a_period_min : assert property (
      @(posedge I_BITCLK) ##2 (period >= period_t'(MIN_PERIOD))
   ) else $error("period_rom: period %0d below minimum", period);

endmodule

// ==== src/square_voice.sv ====
module square_voice
   import square_apu_pkg::*;
(
   input  logic    I_BITCLK,
   input  logic    I_RESET,
   input  logic    strobe,     // one cycle per audio sample
   input  freq_t   freq,       // async settings from here down
   input  duty_t   duty,
   input  vol_t    volume,
   input  logic    enable,
   output sample_t sample      // held until the next strobe
);

   // loudest legal level, volume 15
   localparam sample_t MAX_AMP = sample_t'(((2 ** VOL_W) - 1) * AMP_STEP);

   freq_t   freq_s;            // synchronized settings
   duty_t   duty_s;
   vol_t    vol_s;
   logic    en_s;

   period_t period;            // from the lookup table
   period_t high_len;          // strobes spent at the positive level
   period_t count;             // position inside the period
   period_t count_nxt;
   sample_t amp_pos;
   sample_t amp_neg;

   // settings cross into the bit clock domain
   cfg_sync #(.payload_t(freq_t)) freq_sync_inst (
      .I_BITCLK (I_BITCLK),
      .I_RESET  (I_RESET),
      .async_in (freq),
      .sync_out (freq_s)
   );

   cfg_sync #(.payload_t(duty_t)) duty_sync_inst (
      .I_BITCLK (I_BITCLK),
      .I_RESET  (I_RESET),
      .async_in (duty),
      .sync_out (duty_s)
   );

   cfg_sync #(.payload_t(vol_t)) vol_sync_inst (
      .I_BITCLK (I_BITCLK),
      .I_RESET  (I_RESET),
      .async_in (volume),
      .sync_out (vol_s)
   );

   cfg_sync #(.payload_t(logic)) en_sync_inst (
      .I_BITCLK (I_BITCLK),
      .I_RESET  (I_RESET),
      .async_in (enable),
      .sync_out (en_s)
   );

   // frequency code to period, one edge behind freq_s
   period_rom period_rom_inst (
      .I_BITCLK (I_BITCLK),
      .freq     (freq_s),
      .period   (period)
   );

   // duty split of the period
   always_comb begin
      case (duty_s)
         DUTY_12: high_len = period >> 3;
         DUTY_25: high_len = period >> 2;
         DUTY_50: high_len = period >> 1;
         DUTY_75: high_len = period - (period >> 2);   // 3/4 without overflow
         default: high_len = period >> 1;
      endcase
   end

   // level for the current volume, at most 15 * 16384
   assign amp_pos = sample_t'(vol_s) * sample_t'(AMP_STEP);
   assign amp_neg = -amp_pos;

   // next count, wraps when the period is reached
   // >= also recovers if the period just got shorter
   assign count_nxt = (count + period_t'(1) >= period) ? '0 : count + period_t'(1);

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         count  <= '0;
         sample <= '0;
      end else if (strobe) begin
         if (!en_s) begin
            count  <= '0;          // restart phase when re-enabled
            sample <= '0;
         end else begin
            count <= count_nxt;
            if (count < high_len) begin
               sample <= amp_pos;  // high part of the wave
            end else begin
               sample <= amp_neg;  // rest of the period
            end
         end
      end
   end

   // counter stays inside the period it was stepped against
   a_count_in_period : assert property (
      @(posedge I_BITCLK) disable iff (I_RESET)
      (strobe && en_s) |=> (count < period)
   ) else $error("square_voice: count %0d not below period %0d", count, period);

   // disabled voice is silent after the strobe
   a_disabled_silent : assert property (
      @(posedge I_BITCLK) disable iff (I_RESET)
      (strobe && !en_s) |=> (sample == '0)
   ) else $error("square_voice: disabled voice gave sample %0h", sample);

   // output never beyond full scale of the volume range
   a_sample_range : assert property (
      @(posedge I_BITCLK) disable iff (I_RESET)
      (sample <= MAX_AMP) && (sample >= -MAX_AMP)
   ) else $error("square_voice: sample %0d out of range", sample);

endmodule

// ==== src/square_apu_top.sv ====
module square_apu_top
   import square_apu_pkg::*;
(
   input  logic    I_BITCLK,
   input  logic    I_RESET,
   input  logic    strobe,        // shared sample strobe

   // voice 0 settings, left channel
   input  freq_t   freq0,
   input  duty_t   duty0,
   input  vol_t    volume0,
   input  logic    enable0,

   // voice 1 settings, right channel
   input  freq_t   freq1,
   input  duty_t   duty1,
   input  vol_t    volume1,
   input  logic    enable1,

   output sample_t sample_left,
   output sample_t sample_right
);

   // no mixing, each voice owns one channel

   square_voice voice0_inst (
      .I_BITCLK (I_BITCLK),
      .I_RESET  (I_RESET),
      .strobe   (strobe),
      .freq     (freq0),
      .duty     (duty0),
      .volume   (volume0),
      .enable   (enable0),
      .sample   (sample_left)
   );

   square_voice voice1_inst (
      .I_BITCLK (I_BITCLK),
      .I_RESET  (I_RESET),
      .strobe   (strobe),
      .freq     (freq1),
      .duty     (duty1),
      .volume   (volume1),
      .enable   (enable1),
      .sample   (sample_right)
   );

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock #(
   parameter int PERIOD = 10   // time units per cycle
) (
   output logic clk
);

   initial begin
      clk = 1'b0;              // start low so the first edge is rising
   end

   always begin
      #(PERIOD / 2) clk = ~clk;   // half period per phase
   end

endmodule

// ==== dv/square_apu_tb.sv ====
module square_apu_tb
   import square_apu_pkg::*;
();

   localparam int STROBE_GAP = 6;   // cycles from one strobe to the next
   localparam int SETTLE     = 6;   // cycles to wait out the 4 edge setting latency
   localparam int RESET_CYC  = 10;

   // one row of the stimulus table
   // per0 and per1 hold hand-worked periods or 0 where none is given
   typedef struct packed {
      freq_t      freq0;
      duty_t      duty0;
      vol_t       vol0;
      logic       en0;
      freq_t      freq1;
      duty_t      duty1;
      vol_t       vol1;
      logic       en1;
      logic [7:0] strobes;
      logic [7:0] off_at;   // strobe index where voice 0 goes off or ff for never
      period_t    per0;
      period_t    per1;
   } row_t;

   logic    I_BITCLK;
   logic    I_RESET;
   logic    strobe;
   freq_t   freq0, freq1;
   duty_t   duty0, duty1;
   vol_t    volume0, volume1;
   logic    enable0, enable1;
   sample_t sample_left, sample_right;

   row_t    rows [$];

   // model state per voice
   freq_t   cur_freq [2];
   duty_t   cur_duty [2];
   vol_t    cur_vol  [2];
   logic    cur_en   [2];
   int      model_count [2];

   int      test_errs;       // mismatches inside the running test
   int      n_pass;
   int      n_fail;
   int      cycle_count;
   int      cycle_limit;     // 0 until the table is built

   tb_clock #(.PERIOD(10)) clock_inst (
      .clk (I_BITCLK)
   );

   square_apu_top square_apu_top_inst (
      .I_BITCLK     (I_BITCLK),
      .I_RESET      (I_RESET),
      .strobe       (strobe),
      .freq0        (freq0),
      .duty0        (duty0),
      .volume0      (volume0),
      .enable0      (enable0),
      .freq1        (freq1),
      .duty1        (duty1),
      .volume1      (volume1),
      .enable1      (enable1),
      .sample_left  (sample_left),
      .sample_right (sample_right)
   );

   // watchdog on rising edges
   always @(posedge I_BITCLK) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("timeout: run still going after %0d cycles, limit %0d",
                  cycle_count, cycle_limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   function automatic row_t make_row(
      input freq_t f0, input duty_t d0, input vol_t v0, input logic e0,
      input freq_t f1, input duty_t d1, input vol_t v1, input logic e1,
      input int n, input int off, input int p0, input int p1
   );
      row_t r;
      r.freq0   = f0;
      r.duty0   = d0;
      r.vol0    = v0;
      r.en0     = e0;
      r.freq1   = f1;
      r.duty1   = d1;
      r.vol1    = v1;
      r.en1     = e1;
      r.strobes = 8'(n);
      r.off_at  = 8'(off);
      r.per0    = period_t'(p0);
      r.per1    = period_t'(p1);
      return r;
   endfunction

   task automatic build_table();
      row_t r;
      // short periods across every duty code
      // hand periods are 48000*(2048-code)/131072 rounded down
      rows.push_back(make_row(11'd1920, DUTY_12, 4'd15, 1'b1, 11'd1984, DUTY_25, 4'd7, 1'b1,
                              50, 255, 46, 23));
      rows.push_back(make_row(11'd1920, DUTY_50, 4'd1, 1'b1, 11'd1984, DUTY_75, 4'd15, 1'b1,
                              50, 255, 46, 23));
      // several wraps with 2047 clamped up to MIN_PERIOD
      rows.push_back(make_row(11'd2040, DUTY_50, 4'd7, 1'b1, 11'd2047, DUTY_75, 4'd1, 1'b1,
                              8, 255, 2, 2));
      rows.push_back(make_row(11'd2032, DUTY_25, 4'd15, 1'b1, 11'd2024, DUTY_12, 4'd7, 1'b1,
                              20, 255, 5, 8));
      // volume 0 while enabled and voice 1 off
      rows.push_back(make_row(11'd2016, DUTY_75, 4'd0, 1'b1, 11'd2040, DUTY_50, 4'd15, 1'b0,
                              24, 255, 11, 2));
      // voice 0 switched off mid row while voice 1 keeps running
      rows.push_back(make_row(11'd1984, DUTY_50, 4'd15, 1'b1, 11'd1920, DUTY_75, 4'd1, 1'b1,
                              30, 10, 23, 46));
      // clamped 2044 alternates every strobe at half duty
      rows.push_back(make_row(11'd2044, DUTY_50, 4'd7, 1'b1, 11'd2032, DUTY_50, 4'd1, 1'b1,
                              12, 255, 2, 5));
      // random rows near the top of the code range
      for (int i = 0; i < 6; i++) begin
         r = make_row(freq_t'(2047 - ($urandom % 64)), duty_t'($urandom % 4),
                      vol_t'($urandom % 16), ($urandom % 4) != 0,
                      freq_t'(2047 - ($urandom % 64)), duty_t'($urandom % 4),
                      vol_t'($urandom % 16), ($urandom % 4) != 0,
                      20 + int'($urandom % 20), 255, 0, 0);
         rows.push_back(r);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge I_BITCLK);
   endtask

   // drive one voice's pins and give the model the same values
   task automatic drive_voice(input int v, input freq_t f, input duty_t d,
                              input vol_t vol, input logic en);
      if (v == 0) begin
         freq0   = f;
         duty0   = d;
         volume0 = vol;
         enable0 = en;
      end else begin
         freq1   = f;
         duty1   = d;
         volume1 = vol;
         enable1 = en;
      end
      cur_freq[v] = f;
      cur_duty[v] = d;
      cur_vol[v]  = vol;
      cur_en[v]   = en;
   endtask

   // sample rule on one strobe using the count from before it
   task automatic advance_model(input int v, output sample_t exp);
      int per;
      int high;
      int mag;
      if (!cur_en[v]) begin
         exp            = '0;
         model_count[v] = 0;
      end else begin
         per = int'(strobes_per_period(cur_freq[v]));
         case (duty_e'(cur_duty[v]))
            DUTY_12: high = per / 8;
            DUTY_25: high = per / 4;
            DUTY_50: high = per / 2;
            default: high = per - per / 4;   // 75 percent
         endcase
         mag = int'(cur_vol[v]) * AMP_STEP;
         if (model_count[v] < high) begin
            exp = sample_t'(mag);
         end else begin
            exp = sample_t'(-mag);
         end
         model_count[v] = model_count[v] + 1;
         if (model_count[v] == per) begin
            model_count[v] = 0;                // wrap at the period
         end
      end
   endtask

   task automatic check_sample(input string name, input sample_t exp, input sample_t act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%05h actual 0x%05h", name, exp, act);
         test_errs = test_errs + 1;
      end
   endtask

   task automatic check_period(input string name, input period_t exp, input period_t act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%03h actual 0x%03h", name, exp, act);
         test_errs = test_errs + 1;
      end
   endtask

   // one strobe pulse checked on the next falling edge
   task automatic send_strobe();
      sample_t exp_l;
      sample_t exp_r;
      strobe = 1'b1;
      advance_model(0, exp_l);
      advance_model(1, exp_r);
      @(negedge I_BITCLK);
      strobe = 1'b0;
      check_sample("sample_left", exp_l, sample_left);
      check_sample("sample_right", exp_r, sample_right);
      wait_cycles(STROBE_GAP - 1);
   endtask

   task automatic close_test(input string label);
      if (test_errs == 0) begin
         n_pass = n_pass + 1;
         $display("%s ok", label);
      end else begin
         n_fail = n_fail + 1;
         $display("%s bad, %0d mismatches", label, test_errs);
      end
   endtask

   initial begin
      int total;
      void'($urandom(32'haeef_b89e));
      I_RESET     = 1'b1;
      strobe      = 1'b0;
      cycle_count = 0;
      cycle_limit = 0;
      n_pass      = 0;
      n_fail      = 0;
      test_errs   = 0;
      model_count[0] = 0;
      model_count[1] = 0;
      drive_voice(0, '0, '0, '0, 1'b0);
      drive_voice(1, '0, '0, '0, 1'b0);

      build_table();
      total = RESET_CYC + 20;   // reset test
      foreach (rows[i]) begin
         total = total + int'(rows[i].strobes) * STROBE_GAP + 30;
      end
      cycle_limit = 2 * total;

      wait_cycles(RESET_CYC);
      I_RESET = 1'b0;

      // silent after reset before and during disabled strobes
      @(negedge I_BITCLK);
      check_sample("sample_left", '0, sample_left);
      check_sample("sample_right", '0, sample_right);
      send_strobe();
      send_strobe();
      close_test("reset test");

      foreach (rows[i]) begin
         test_errs = 0;
         // both voices off so two strobes clear the counters
         drive_voice(0, cur_freq[0], cur_duty[0], cur_vol[0], 1'b0);
         drive_voice(1, cur_freq[1], cur_duty[1], cur_vol[1], 1'b0);
         wait_cycles(SETTLE);
         send_strobe();
         send_strobe();

         drive_voice(0, rows[i].freq0, rows[i].duty0, rows[i].vol0, rows[i].en0);
         drive_voice(1, rows[i].freq1, rows[i].duty1, rows[i].vol1, rows[i].en1);
         wait_cycles(SETTLE);
         if (rows[i].per0 != '0) begin
            check_period("voice0 period", rows[i].per0,
                         square_apu_top_inst.voice0_inst.period);
         end
         if (rows[i].per1 != '0) begin
            check_period("voice1 period", rows[i].per1,
                         square_apu_top_inst.voice1_inst.period);
         end

         for (int s = 0; s < int'(rows[i].strobes); s++) begin
            if (s == int'(rows[i].off_at)) begin
               drive_voice(0, cur_freq[0], cur_duty[0], cur_vol[0], 1'b0);
               wait_cycles(SETTLE);
            end
            send_strobe();
         end
         close_test($sformatf("row %0d (%0d strobes)", i, rows[i].strobes));
      end

      $display("tests passed %0d failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== square_apu.f ====
src/square_apu_pkg.sv
src/cfg_sync.sv
src/period_rom.sv
src/square_voice.sv
src/square_apu_top.sv
dv/tb_clock.sv
dv/square_apu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the testbench with verilator, run it, then search the log for the fail line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module square_apu_tb \
   -f square_apu.f -o square_apu_sim > build.log 2>&1 \
   || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/square_apu_sim > sim.log 2>&1 \
   || { cat sim.log; echo "simulation exited with an error status"; exit 1; }

cat sim.log
grep -q '\*\*\* TEST FAILED \*\*\*' sim.log && { echo "failure reported in sim.log"; exit 1; }
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
